/* all.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/core_fetch.sv
hdl/core_prefetch.sv
hdl/core_decode.sv
hdl/core_frontend.sv
bench/tb_frontend.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal --timescale 1ns/1ps
TOP       = tb_frontend
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* bench/tb_frontend.sv */
`include "core_macros.svh"

module tb_frontend;
	timeunit 1ns;
	timeprecision 1ps;

	import core_pkg::*;

	localparam int total_records = 24 + 300 + 60 + 20 + 30;

	logic clk, rst_n, halt, redirect, bus_start, bus_write, bus_ready, halted, dec_req, dec_ack;
	ptr redirect_pc, bus_addr;
	word bus_data_rd, bus_data_wr;
	logic[3:0] bus_data_be;
	insn_decode dec_out, held;

	string test_name = "reset";
	int errors = 0, tests_run = 0, rec_count = 0, ack_max = 3;
	ptr exp_pc = `CORE_RESET_VECTOR, old_pc;
	bit old_ok, req_seen, bus_busy;
	bit[7:0] class_seen;
	logic[31:0] ctl_rng = 32'd42, ack_rng = 32'd42 ^ 32'h0000_a5a5, bus_rng = 32'd42 ^ 32'h005a_0000;

	core_frontend dut0 (.*);

	function automatic logic[31:0] xorshift(input logic[31:0] x);
		logic[31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// low addresses hold one word of every class, the rest is hashed.
	function automatic word mem_word(input ptr addr);
		case (addr)
			32'h00:  return 32'he0812003; // add r2, r1, r3.
			32'h04:  return 32'he0000291; // mul.
			32'h08:  return 32'he5912004; // ldr immediate.
			32'h0c:  return 32'he7912003; // ldr register.
			32'h10:  return 32'he7f000f0; // undefined media slot.
			32'h14:  return 32'he8bd8000; // ldm.
			32'h18:  return 32'heafffffe; // backward branch.
			32'h1c:  return 32'hed9f0a00; // ldc.
			32'h20:  return 32'hee010f10; // mcr.
			32'h24:  return 32'hef000011; // swi.
			default: return xorshift(addr);
		endcase
	endfunction

	function automatic insn_decode expected_record(input ptr pc);
		insn_decode r;
		word w;
		w = mem_word(pc);
		r.pc = pc;
		r.insn = w;
		r.cond = w[31:28];
		r.rn = w[19:16];
		r.rd = w[15:12];
		case (w[27:25])
			3'b000:  r.cls = (w[7:4] == 4'b1001) ? multiply : data_proc;
			3'b001:  r.cls = data_proc;
			3'b010:  r.cls = load_store;
			3'b011:  r.cls = w[4] ? undefined : load_store;
			3'b100:  r.cls = block_xfer;
			3'b101:  r.cls = branch;
			3'b110:  r.cls = coproc;
			default: r.cls = w[24] ? swi : coproc;
		endcase
		r.branch_target = pc + ptr'(8) + ptr'($signed({w[23:0], 8'h00}) >>> 6); // offset times four.
		return r;
	endfunction

	task automatic check_ptr(input ptr expected, input ptr actual, input string what);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_decode(input insn_decode expected, input insn_decode actual,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input logic expected, input logic actual, input string what);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %b, actual %b", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_write_idle(input logic write, input word data, input logic[3:0] be);
		if (write !== 1'b0 || data !== '0 || be !== 4'b0000) begin
			$display("[ERROR] %s write side: expected 0 %h 0000, actual %b %h %b",
				test_name, word'(0), write, data, be);
			errors++;
		end
	endtask

	task automatic take_record(input insn_decode rec);
		if (old_ok && rec.pc == old_pc && rec.pc != exp_pc)
			old_ok = 1'b0; // offered before the redirect.
		else begin
			check_ptr(exp_pc, rec.pc, "record pc");
			exp_pc = rec.pc + ptr'(4);
			old_ok = 1'b0;
		end
		check_decode(expected_record(rec.pc), rec, "decoded record");
		class_seen[rec.cls] = 1'b1;
		rec_count++;
	endtask

	task automatic report_test(input string name, input int first_error);
		tests_run++;
		$display("test %s: %0d records so far, %0d errors", name, rec_count, errors - first_error);
	endtask

	task automatic run_records(input string name, input int count, input bit jumps, input int slack);
		int first_error;
		int target;
		logic[31:0] pick;
		test_name = name;
		ack_max = slack;
		first_error = errors;
		target = rec_count + count;
		while (rec_count < target) begin
			@(posedge clk);
			ctl_rng = xorshift(ctl_rng);
			pick = xorshift(ctl_rng);
			#5;
			redirect = jumps && ctl_rng[4:0] == 5'd0;
			redirect_pc = {pick[31:2], 2'b00};
		end
		@(posedge clk);
		#5 redirect = 1'b0;
		report_test(name, first_error);
	endtask

	task automatic run_halt(input string name, input int count);
		int first_error;
		int target;
		test_name = name;
		ack_max = 3;
		first_error = errors;
		@(posedge clk);
		#5 halt = 1'b1;
		@(posedge clk);
		while (!halted)
			@(posedge clk);
		repeat (40) begin
			@(posedge clk);
			if (bus_start) begin
				$display("%s: bus_start went high while the fetch unit was halted", name);
				errors++;
			end
		end
		#5 halt = 1'b0;
		target = rec_count + count;
		while (rec_count < target)
			@(posedge clk);
		report_test(name, first_error);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// sequence model, sampled on the clock edge.
	always @(posedge clk) begin
		if (rst_n && dec_req && !req_seen) begin
			take_record(dec_out);
			held = dec_out;
		end else if (rst_n && dec_req)
			check_decode(held, dec_out, "held record");
		req_seen = rst_n && dec_req;
		if (rst_n) begin
			check_bit(halt && !(bus_start || bus_busy), halted, "halted");
			check_write_idle(bus_write, bus_data_wr, bus_data_be);
		end
		// a read is in flight from its start until its ready cycle.
		bus_busy = rst_n && (bus_busy || bus_start) && !bus_ready;
		if (rst_n && redirect) begin
			old_ok = 1'b1;
			old_pc = exp_pc;
			exp_pc = redirect_pc;
		end
	end

	initial begin : bus_slave
		ptr addr;
		int lat;
		forever begin
			@(posedge clk);
			if (bus_start) begin
				addr = bus_addr;
				check_ptr(ptr'(0), addr & ptr'(3), "bus address low bits");
				bus_rng = xorshift(bus_rng);
				lat = 1 + int'(bus_rng[1:0]);
				repeat (lat - 1) @(posedge clk);
				#5;
				bus_ready = 1'b1;
				bus_data_rd = mem_word(addr);
				@(posedge clk);
				#5 bus_ready = 1'b0;
			end
		end
	end

	initial begin : ack_side
		int delay;
		forever begin
			@(posedge clk);
			if (dec_req != dec_ack) begin
				ack_rng = xorshift(ack_rng);
				delay = int'(ack_rng % 32'(ack_max + 1));
				repeat (delay) @(posedge clk);
				#5 dec_ack = !dec_ack;
			end
		end
	end

	initial begin : watchdog
		repeat (64 * total_records) @(posedge clk);
		$display("timeout: the record stream stalled before all tests finished");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		halt = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		bus_ready = 1'b0;
		bus_data_rd = '0;
		dec_ack = 1'b0;
		repeat (16) @(posedge clk);
		#5 rst_n = 1'b1;
		run_records("reset_sequence", 24, 1'b0, 3);
		run_records("random_redirect", 300, 1'b1, 3);
		run_records("slow_ack", 60, 1'b0, 12);
		run_halt("halt_window", 20);
		run_records("redirect_slow_ack", 30, 1'b1, 8);
		for (int i = 0; i < 8; i++)
			if (!class_seen[i]) begin
				$display("no record of instruction class %0d was decoded", i);
				errors++;
			end
		$display("tests run: %0d, records: %0d, errors: %0d", tests_run, rec_count, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* hdl/core_frontend.sv */
`include "core_macros.svh"

module core_frontend
(
	input  logic                 clk,
	                             rst_n,
	                             halt,
	                             redirect,
	input  core_pkg::ptr         redirect_pc,

	output core_pkg::ptr         bus_addr,
	output logic                 bus_start,
	                             bus_write,
	input  logic                 bus_ready,
	input  core_pkg::word        bus_data_rd,
	output core_pkg::word        bus_data_wr,
	output logic[3:0]            bus_data_be,

	output logic                 halted,

	output core_pkg::insn_decode dec_out,
	output logic                 dec_req,
	input  logic                 dec_ack
);

	import core_pkg::*;

	fetch_entry push_entry, head_entry;
	logic push, pop, empty, space;

	// instruction side only, no data stores.
	assign bus_write = 1'b0;
	assign bus_data_wr = '0;
	assign bus_data_be = 4'b0000;

	core_fetch fetch
	(
		.entry(push_entry),
		.*
	);

	core_prefetch #(.depth(`CORE_PREFETCH_DEPTH)) prefetch
	(
		.flush(redirect),
		.wr_entry(push_entry),
		.rd_entry(head_entry),
		.*
	);

	core_decode decode
	(
		.entry(head_entry),
		.*
	);

endmodule

/* hdl/core_decode.sv */
module core_decode
(
	input  logic                 clk,
	                             rst_n,
	                             empty,
	input  core_pkg::fetch_entry entry,
	output logic                 pop,

	output core_pkg::insn_decode dec_out,
	output logic                 dec_req,
	input  logic                 dec_ack
);

	import core_pkg::*;

	typedef enum logic[1:0]
	{
		s_idle,
		s_req,
		s_wait
	} hs_state;

	hs_state state;

	function automatic insn_class classify(input word insn);
		insn_class cls;

		case (insn[27:25])
			3'b000:  cls = insn[7:4] == 4'b1001 ? multiply : data_proc;
			3'b001:  cls = data_proc;
			3'b010:  cls = load_store;
			3'b011:  cls = insn[4] ? undefined : load_store; // media space.
			3'b100:  cls = block_xfer;
			3'b101:  cls = branch;
			3'b110:  cls = coproc;
			default: cls = insn[24] ? swi : coproc;
		endcase

		return cls;
	endfunction

	function automatic insn_decode decode_insn(input fetch_entry e);
		insn_decode d;

		d.pc = e.pc;
		d.insn = e.insn;
		d.cond = e.insn[31:28];
		d.cls = classify(e.insn);
		d.rd = e.insn[15:12];
		d.rn = e.insn[19:16];
		// pc reads two words ahead.
		d.branch_target = e.pc + ptr'(8) + {{6{e.insn[23]}}, e.insn[23:0], 2'b00};

		return d;
	endfunction

	assign pop = state == s_idle && !empty;
	assign dec_req = state == s_req;

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= s_idle;
		else
			unique case (state)
				s_idle:
					if (!empty)
						state <= s_req;

				s_req:
					if (dec_ack)
						state <= s_wait;

				s_wait:
					if (!dec_ack)
						state <= s_idle; // ack gone, next pop allowed.

				default:
					state <= s_idle;
			endcase
	end

	always_ff @(posedge clk) begin
		if (pop)
			dec_out <= decode_insn(entry);
	end

	dec_out_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		dec_req && !dec_ack |=> $stable(dec_out)
	) else $error("dec_out changed during request");

endmodule

/* hdl/core_prefetch.sv */
`include "core_macros.svh"

module core_prefetch
#(
	parameter int depth = `CORE_PREFETCH_DEPTH
)
(
	input  logic                 clk,
	                             rst_n,
	                             flush,
	                             push,
	                             pop,
	input  core_pkg::fetch_entry wr_entry,
	output core_pkg::fetch_entry rd_entry,
	output logic                 empty,
	                             space
);

	import core_pkg::*;

	localparam int idx_w = depth > 1 ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	fetch_entry mem[depth];
	logic[idx_w-1:0] wr_idx, rd_idx;
	logic[cnt_w-1:0] count;

	function automatic logic[idx_w-1:0] next_idx(input logic[idx_w-1:0] idx);
		if (int'(idx) == depth - 1)
			return '0;
		else
			return idx + 1'b1;
	endfunction

	if (depth < 2) begin : depth_check
		$error("prefetch depth must be at least two");
	end

	assign empty = count == '0;
	assign space = int'(count) + 2 <= depth; // room for a push plus the read in flight.
	assign rd_entry = mem[rd_idx];

	always_ff @(posedge clk) begin
		if (push && !flush)
			mem[wr_idx] <= wr_entry;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_idx <= next_idx(wr_idx);
			if (pop)
				rd_idx <= next_idx(rd_idx);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		push |-> count != cnt_w'(depth)
	) else $error("push into a full prefetch buffer");

	no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop |-> !empty
	) else $error("pop from an empty prefetch buffer");

endmodule

/* hdl/core_fetch.sv */
`include "core_macros.svh"

module core_fetch
(
	input  logic                 clk,
	                             rst_n,
	                             halt,
	                             redirect,
	input  core_pkg::ptr         redirect_pc,

	input  logic                 bus_ready,
	input  core_pkg::word        bus_data_rd,
	output core_pkg::ptr         bus_addr,
	output logic                 bus_start,

	input  logic                 space,
	output logic                 push,
	output core_pkg::fetch_entry entry,

	output logic                 halted
);

	import core_pkg::*;

	ptr pc;
	logic outstanding, drop, issue, accept;

	assign bus_addr = pc;

	// a start pulse counts as a transfer in flight.
	assign halted = halt && !outstanding && !bus_start;

	// one read at a time, the next one may go out right after ready.
	assign issue = (!outstanding || bus_ready) && !bus_start && space && !halt;

	// data of a read that a redirect overtook is thrown away.
	assign accept = bus_ready && !drop && !redirect;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CORE_RESET_VECTOR;
			bus_start <= 1'b0;
			outstanding <= 1'b0;
			push <= 1'b0;
		end else begin
			bus_start <= issue;
			push <= accept;

			if (bus_start)
				outstanding <= 1'b1;
			else if (bus_ready)
				outstanding <= 1'b0;

			if (redirect)
				pc <= {redirect_pc[`CORE_WORD_W-1:2], 2'b00}; // force word alignment.
			else if (accept)
				pc <= pc + ptr'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			drop <= 1'b0;
		else if (redirect && (bus_start || (outstanding && !bus_ready)))
			drop <= 1'b1;
		else if (bus_ready)
			drop <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept)
			entry <= fetch_entry'{pc: pc, insn: bus_data_rd};
	end

	no_start_outstanding: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus_start |-> !outstanding
	) else $error("bus_start while a read is outstanding");

endmodule

/* hdl/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

	typedef logic [`CORE_WORD_W-1:0] ptr; // byte address.

	typedef logic [`CORE_WORD_W-1:0] word;

	typedef logic [3:0] cond_code;

	typedef enum logic [2:0]
	{
		data_proc,
		multiply,
		load_store,
		block_xfer,
		branch,
		coproc,
		swi,
		undefined
	} insn_class;

	// one fetched word and the address it came from.
	typedef struct packed
	{
		ptr  pc;
		word insn;
	} fetch_entry;

	typedef struct packed
	{
		ptr        pc;
		word       insn;
		cond_code  cond;
		insn_class cls;
		logic[3:0] rd;
		logic[3:0] rn;
		ptr        branch_target; // only meaningful for branch.
	} insn_decode;

endpackage

/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first instruction address after reset.
`define CORE_RESET_VECTOR 32'h0000_0000

// default number of prefetch buffer entries.
`define CORE_PREFETCH_DEPTH 4

// instruction and data word width.
`define CORE_WORD_W 32

`endif
